// File: core_settings.svh
/*
  Register map and build constants for the control core.
  Addresses are word addresses; only the low CORE_SR_AWIDTH bits are decoded.
*/
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// number of setting registers behind the host port
`define CORE_NUM_SREGS   4

// significant address bits per register compare
`define CORE_SR_AWIDTH   11

// setting register word addresses
`define CORE_SR_READBACK 11'd0
`define CORE_SR_MISC     11'd4
`define CORE_SR_TEST     11'd28
`define CORE_SR_XB_LOCAL 11'd32

// readback constants
`define CORE_COMPAT_WORD {8'hAC, 8'h00, 8'h0B, 8'h00}
`define CORE_GIT_HASH    32'h5f3a91c7

`endif

// File: core_pkg.sv
/*
  Shared types and register tables for the control core.
  Table order fixes the register index used by the readback mux and the top level.
*/
`default_nettype none
`include "core_settings.svh"

package core_pkg;

  typedef logic [31:0] sreg_word_t;
  typedef logic [`CORE_SR_AWIDTH-1:0] sreg_addr_t;

  // host request, held stable for the whole handshake
  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [31:0] data;
  } set_req_t;

  // internal write broadcast to every setting register
  typedef struct packed {
    logic        stb;
    logic [31:0] addr;
    logic [31:0] data;
  } set_wr_t;

  // misc register layout, msb first
  typedef struct packed {
    logic [9:0] reserved;
    logic       time_sync;
    logic [3:0] rx_bandsel_c;
    logic [3:0] rx_bandsel_b;
    logic [5:0] rx_bandsel_a;
    logic [2:0] tx_bandsel;
    logic       codec_arst;
    logic       mimo;
    logic [1:0] pps_select;
  } misc_ctrl_t;

  typedef enum logic [4:0] {
    RB_MISC    = 5'd1,
    RB_COMPAT  = 5'd2,
    RB_GITHASH = 5'd3,
    RB_PLL     = 5'd4,
    RB_DEBUG   = 5'd5,
    RB_TEST    = 5'd24
  } rb_sel_e;

  // register index in the tables below
  localparam int IDX_READBACK = 0;
  localparam int IDX_MISC     = 1;
  localparam int IDX_TEST     = 2;
  localparam int IDX_XB_LOCAL = 3;

  localparam sreg_addr_t SREG_ADDR [`CORE_NUM_SREGS] = '{
    `CORE_SR_READBACK, `CORE_SR_MISC, `CORE_SR_TEST, `CORE_SR_XB_LOCAL
  };

  // misc resets to pps select 2'b10, the internal pps
  localparam sreg_word_t SREG_RESET [`CORE_NUM_SREGS] = '{
    32'h0, 32'h2, 32'h0, 32'd40
  };

endpackage

`default_nettype wire

// File: settings_bus_port.sv
/*
  Four-phase req/ack slave; the host keeps i_req_bus stable while i_req or o_ack is high.
  One write strobe per transaction, ack two cycles after req, no back-pressure.
*/
`timescale 1ns/100ps
`default_nettype none

module settings_bus_port (
  input  wire logic                 i_bus_clk,
  input  wire logic                 i_bus_rst,
  input  wire logic                 i_req,
  input  wire core_pkg::set_req_t   i_req_bus,
  output logic                      o_ack,
  output core_pkg::sreg_word_t      o_rb_data,
  output core_pkg::set_wr_t         o_wr,
  input  wire core_pkg::sreg_word_t i_rb_word
);

  import core_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_ACK,
    ST_RELEASE
  } port_state_e;

  port_state_e state;
  logic        wr_stb;
  sreg_word_t  wr_addr;
  sreg_word_t  wr_data;

  //////////////////////////////////////////////////////////////////////
  // handshake FSM
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      state  <= ST_IDLE;
      wr_stb <= 1'b0;
    end else begin
      wr_stb <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_req) begin
            state  <= ST_EXEC;
            wr_stb <= i_req_bus.wr;
          end
        end
        // strobe is high here; registers load at the end of this cycle
        ST_EXEC:    state <= ST_ACK;
        ST_ACK:     state <= ST_RELEASE;
        // wait for the host to drop req, a held req never writes twice
        ST_RELEASE: begin
          if (!i_req) begin
            state <= ST_IDLE;
          end
        end
        default:    state <= ST_IDLE;
      endcase
    end
  end

  // payload capture
  always_ff @(posedge i_bus_clk) begin
    if (state == ST_IDLE && i_req) begin
      wr_addr <= i_req_bus.addr;
      wr_data <= i_req_bus.data;
    end
    if (state == ST_ACK) begin
      o_rb_data <= i_rb_word;
    end
  end

  assign o_ack = (state == ST_RELEASE);

  assign o_wr.stb  = wr_stb;
  assign o_wr.addr = wr_addr;
  assign o_wr.data = wr_data;

endmodule

`default_nettype wire

// File: setting_reg.sv
/*
  Address-matched 32-bit setting register; compares the low address bits only.
*/
`timescale 1ns/100ps
`default_nettype none

module setting_reg #(
  parameter core_pkg::sreg_addr_t MY_ADDR  = '0,
  parameter core_pkg::sreg_word_t AT_RESET = '0
) (
  input  wire logic              i_bus_clk,
  input  wire logic              i_bus_rst,
  input  wire core_pkg::set_wr_t i_wr,
  output core_pkg::sreg_word_t   o_value
);

  logic hit;

  // upper address bits are ignored
  assign hit = i_wr.stb && (i_wr.addr[$bits(MY_ADDR)-1:0] == MY_ADDR);

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      o_value <= AT_RESET;
    end else if (hit) begin
      o_value <= i_wr.data;
    end
  end

endmodule

`default_nettype wire

// File: readback_mux.sv
/*
  Readback word select, combinational from the registers.
  Lock bits are double-flopped into bus_clk and show up two cycles late.
*/
`timescale 1ns/100ps
`default_nettype none
`include "core_settings.svh"

module readback_mux (
  input  wire logic                 i_bus_clk,
  input  wire logic                 i_bus_rst,
  input  wire core_pkg::sreg_word_t i_sregs [`CORE_NUM_SREGS],
  input  wire logic [3:0]           i_tcxo_status,
  input  wire logic [1:0]           i_lock_signals,
  output core_pkg::sreg_word_t      o_rb_word
);

  import core_pkg::*;

  logic [1:0] lock_meta;
  logic [1:0] lock_sync;
  rb_sel_e    rb_sel;
  misc_ctrl_t misc;

  //////////////////////////////////////////////////////////////////////
  // pll lock synchronizer
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      lock_meta <= 2'b00;
      lock_sync <= 2'b00;
    end else begin
      lock_meta <= i_lock_signals;
      lock_sync <= lock_meta;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // select decode
  //////////////////////////////////////////////////////////////////////
  // only the low 5 bits of the select register matter
  assign rb_sel = rb_sel_e'(i_sregs[IDX_READBACK][4:0]);
  assign misc   = misc_ctrl_t'(i_sregs[IDX_MISC]);

  always_comb begin
    case (rb_sel)
      RB_TEST:    o_rb_word = i_sregs[IDX_TEST];
      RB_MISC:    o_rb_word = {26'd0, i_tcxo_status, misc.pps_select};
      RB_COMPAT:  o_rb_word = `CORE_COMPAT_WORD;
      RB_GITHASH: o_rb_word = `CORE_GIT_HASH;
      RB_PLL:     o_rb_word = {30'd0, lock_sync};
      // debug has no source in this core and reads like any unmapped code
      default:    o_rb_word = 32'hdeadbeef;
    endcase
  end

endmodule

`default_nettype wire

// File: radio_ctrl_core.sv
/*
  Control plane top: host req/ack port, setting registers and readback mux.
  Crossbar, radios and time-sync synchronizer live outside; time_sync is bus_clk.
*/
`timescale 1ns/100ps
`default_nettype none
`include "core_settings.svh"

module radio_ctrl_core (
  input  wire logic               i_bus_clk,
  input  wire logic               i_bus_rst,

  // host port
  input  wire logic               i_req,
  input  wire core_pkg::set_req_t i_req_bus,
  output logic                    o_ack,
  output core_pkg::sreg_word_t    o_rb_data,

  // status
  input  wire logic [3:0]         i_tcxo_status,
  input  wire logic [1:0]         i_lock_signals,

  // controls
  output logic [1:0]              o_pps_select,
  output logic                    o_mimo,
  output logic                    o_codec_arst,
  output logic [2:0]              o_tx_bandsel,
  output logic [5:0]              o_rx_bandsel_a,
  output logic [3:0]              o_rx_bandsel_b,
  output logic [3:0]              o_rx_bandsel_c,
  output logic                    o_time_sync,
  output logic [7:0]              o_xb_local_addr
);

  import core_pkg::*;

  set_wr_t    wr;
  sreg_word_t sregs [`CORE_NUM_SREGS];
  sreg_word_t rb_word;
  misc_ctrl_t misc;

  settings_bus_port u_port (
    .i_bus_clk (i_bus_clk),
    .i_bus_rst (i_bus_rst),
    .i_req     (i_req),
    .i_req_bus (i_req_bus),
    .o_ack     (o_ack),
    .o_rb_data (o_rb_data),
    .o_wr      (wr),
    .i_rb_word (rb_word)
  );

  //////////////////////////////////////////////////////////////////////
  // setting registers
  //////////////////////////////////////////////////////////////////////
  for (genvar gi = 0; gi < `CORE_NUM_SREGS; gi++) begin : g_sreg
    setting_reg #(
      .MY_ADDR  (SREG_ADDR[gi]),
      .AT_RESET (SREG_RESET[gi])
    ) u_sreg (
      .i_bus_clk (i_bus_clk),
      .i_bus_rst (i_bus_rst),
      .i_wr      (wr),
      .o_value   (sregs[gi])
    );
  end

  readback_mux u_rb_mux (
    .i_bus_clk      (i_bus_clk),
    .i_bus_rst      (i_bus_rst),
    .i_sregs        (sregs),
    .i_tcxo_status  (i_tcxo_status),
    .i_lock_signals (i_lock_signals),
    .o_rb_word      (rb_word)
  );

  // misc word fans out to the control pins
  assign misc            = misc_ctrl_t'(sregs[IDX_MISC]);
  assign o_pps_select    = misc.pps_select;
  assign o_mimo          = misc.mimo;
  assign o_codec_arst    = misc.codec_arst;
  assign o_tx_bandsel    = misc.tx_bandsel;
  assign o_rx_bandsel_a  = misc.rx_bandsel_a;
  assign o_rx_bandsel_b  = misc.rx_bandsel_b;
  assign o_rx_bandsel_c  = misc.rx_bandsel_c;
  assign o_time_sync     = misc.time_sync;

  // crossbar local address, low byte only
  assign o_xb_local_addr = sregs[IDX_XB_LOCAL][7:0];

endmodule

`default_nettype wire

// File: tb_radio_ctrl_core.sv
/*
  Replays core_patterns.txt through the req/ack port; run from the project root.
  Random data goes to the test register only, op codes are listed in the pattern file.
*/
`timescale 1ns/100ps
`default_nettype none
`include "core_settings.svh"

module tb_radio_ctrl_core;

  import core_pkg::*;

  localparam int          CLK_PERIOD = 100;
  localparam int          DRIVE_SKEW = 10;
  localparam logic [31:0] RAND_SEED  = 32'haed2_c949;

  // one line of the pattern file
  typedef struct packed {
    logic [3:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  tcxo;
    logic [1:0]  lock;
    logic [31:0] exp_word;
    logic [7:0]  exp_xb;
  } pattern_t;

  logic       bus_clk;
  logic       bus_rst;
  logic       req;
  set_req_t   req_bus;
  logic       ack;
  sreg_word_t rb_data;
  logic [3:0] tcxo_status;
  logic [1:0] lock_signals;
  logic [1:0] pps_select;
  logic       mimo;
  logic       codec_arst;
  logic [2:0] tx_bandsel;
  logic [5:0] rx_bandsel_a;
  logic [3:0] rx_bandsel_b;
  logic [3:0] rx_bandsel_c;
  logic       time_sync;
  logic [7:0] xb_local_addr;

  pattern_t   patterns [$];
  sreg_word_t test_word;
  logic       patterns_loaded = 1'b0;
  int         error_count = 0;
  int         check_count = 0;

  radio_ctrl_core UUT (
    .i_bus_clk       (bus_clk),
    .i_bus_rst       (bus_rst),
    .i_req           (req),
    .i_req_bus       (req_bus),
    .o_ack           (ack),
    .o_rb_data       (rb_data),
    .i_tcxo_status   (tcxo_status),
    .i_lock_signals  (lock_signals),
    .o_pps_select    (pps_select),
    .o_mimo          (mimo),
    .o_codec_arst    (codec_arst),
    .o_tx_bandsel    (tx_bandsel),
    .o_rx_bandsel_a  (rx_bandsel_a),
    .o_rx_bandsel_b  (rx_bandsel_b),
    .o_rx_bandsel_c  (rx_bandsel_c),
    .o_time_sync     (time_sync),
    .o_xb_local_addr (xb_local_addr)
  );

  always #(CLK_PERIOD / 2) bus_clk = ~bus_clk;

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[FAIL] %s expected %h got %h at %0t", name, expected, actual, $time);
    end
  endtask

  // full four-phase handshake entered and left at the drive point
  task automatic run_transaction(input logic wr, input logic [31:0] addr,
                                 input logic [31:0] data, output sreg_word_t rd);
    req_bus.wr   = wr;
    req_bus.addr = addr;
    req_bus.data = data;
    req          = 1'b1;
    do begin
      @(posedge bus_clk);
      #(DRIVE_SKEW);
    end while (!ack);
    rd  = rb_data;
    req = 1'b0;
    do begin
      @(posedge bus_clk);
      #(DRIVE_SKEW);
    end while (ack);
  endtask

  // control pins against the misc layout of the expected word
  task automatic check_controls(input pattern_t p);
    misc_ctrl_t exp_misc;
    exp_misc = misc_ctrl_t'(p.exp_word);
    check_value("o_pps_select", {30'd0, exp_misc.pps_select}, {30'd0, pps_select});
    check_value("o_mimo", {31'd0, exp_misc.mimo}, {31'd0, mimo});
    check_value("o_codec_arst", {31'd0, exp_misc.codec_arst}, {31'd0, codec_arst});
    check_value("o_tx_bandsel", {29'd0, exp_misc.tx_bandsel}, {29'd0, tx_bandsel});
    check_value("o_rx_bandsel_a", {26'd0, exp_misc.rx_bandsel_a}, {26'd0, rx_bandsel_a});
    check_value("o_rx_bandsel_b", {28'd0, exp_misc.rx_bandsel_b}, {28'd0, rx_bandsel_b});
    check_value("o_rx_bandsel_c", {28'd0, exp_misc.rx_bandsel_c}, {28'd0, rx_bandsel_c});
    check_value("o_time_sync", {31'd0, exp_misc.time_sync}, {31'd0, time_sync});
    check_value("o_xb_local_addr", {24'd0, p.exp_xb}, {24'd0, xb_local_addr});
  endtask

  task automatic load_patterns();
    int          fd;
    int          n;
    string       line;
    pattern_t    p;
    logic [31:0] f_op, f_addr, f_data, f_tcxo, f_lock, f_expw, f_expx;
    fd = $fopen("core_patterns.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("could not open core_patterns.txt for reading");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      // comment and blank lines scan nothing
      n = $sscanf(line, "%h %h %h %h %h %h %h",
                  f_op, f_addr, f_data, f_tcxo, f_lock, f_expw, f_expx);
      if (n == 7) begin
        p.op       = f_op[3:0];
        p.addr     = f_addr;
        p.data     = f_data;
        p.tcxo     = f_tcxo[3:0];
        p.lock     = f_lock[1:0];
        p.exp_word = f_expw;
        p.exp_xb   = f_expx[7:0];
        patterns.push_back(p);
      end
    end
    $fclose(fd);
    if (patterns.size() == 0) begin
      error_count++;
      $display("no pattern lines found in core_patterns.txt");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin : main
    sreg_word_t  rd;
    pattern_t    p;
    bus_clk      = 1'b0;
    bus_rst      = 1'b1;
    req          = 1'b0;
    req_bus      = '0;
    tcxo_status  = '0;
    lock_signals = '0;
    test_word    = '0;
    void'($urandom(RAND_SEED));
    load_patterns();
    patterns_loaded = 1'b1;
    repeat (2) @(posedge bus_clk);
    #(DRIVE_SKEW);
    bus_rst = 1'b0;

    foreach (patterns[i]) begin
      p            = patterns[i];
      tcxo_status  = p.tcxo;
      lock_signals = p.lock;
      case (p.op)
        4'h0: check_controls(p);
        4'h1: begin
          run_transaction(1'b1, p.addr, p.data, rd);
          check_controls(p);
        end
        4'h2: begin
          test_word = $urandom();
          run_transaction(1'b1, p.addr, test_word, rd);
          check_controls(p);
        end
        4'h3: begin
          run_transaction(1'b0, p.addr, p.data, rd);
          check_value("o_rb_data", p.exp_word, rd);
        end
        4'h4: begin
          run_transaction(1'b0, p.addr, p.data, rd);
          check_value("o_rb_data", test_word, rd);
        end
        4'h5: begin
          run_transaction(1'b0, p.addr, p.data, rd);
          check_value("o_rb_data", `CORE_GIT_HASH, rd);
        end
        default: begin
          error_count++;
          $display("pattern %0d has unknown operation %h", i, p.op);
        end
      endcase
    end

    $display("checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // about 5 cycles per transaction against 20 allowed per line
  initial begin : watchdog
    wait (patterns_loaded);
    repeat ((patterns.size() + 4) * 20) @(posedge bus_clk);
    $display("watchdog: run did not finish in time, handshake likely stuck");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: core_patterns.txt
# columns (hex): op addr data tcxo lock exp_word exp_xb
# op: 0 check ports, 1 write, 2 write random, 3 read, 4 read random word, 5 read build hash
0 00000000 00000000 0 0 00000002 28
3 00000000 00000000 0 0 deadbeef 28
1 00000004 0035a7e5 c 0 0035a7e5 28
1 00000000 00000001 c 0 0035a7e5 28
3 00000000 00000000 c 0 00000031 28
2 0000001c 00000000 c 0 0035a7e5 28
1 00000000 00000018 c 0 0035a7e5 28
4 00000000 00000000 c 0 00000000 28
1 00000000 00000002 c 0 0035a7e5 28
3 00000000 00000000 c 0 ac000b00 28
1 00000000 00000003 c 0 0035a7e5 28
5 00000000 00000000 c 0 00000000 28
1 00000000 00000005 c 0 0035a7e5 28
3 00000000 00000000 c 0 deadbeef 28
1 00000000 00000009 c 0 0035a7e5 28
3 00000000 00000000 c 0 deadbeef 28
1 00000000 00000004 c 3 0035a7e5 28
3 00000000 00000000 c 3 00000003 28
1 00000000 00000004 c 2 0035a7e5 28
3 00000000 00000000 c 2 00000002 28
1 00000008 ffffffff c 2 0035a7e5 28
3 00000000 00000000 c 2 00000002 28
1 00000000 00000018 c 2 0035a7e5 28
4 00000000 00000000 c 2 00000000 28
1 00000020 123456a5 c 2 0035a7e5 a5
0 00000000 00000000 c 2 0035a7e5 a5

// File: verilog.f
+incdir+.
core_pkg.sv
settings_bus_port.sv
setting_reg.sv
readback_mux.sv
radio_ctrl_core.sv
tb_radio_ctrl_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the radio control core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_radio_ctrl_core
OBJ_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --timescale 1ns/100ps \
  --top-module "$TOP" --Mdir "$OBJ_DIR" -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
